/* verilog/shell_pkg.sv */
/*
 * shared widths and packed structs for the console shell
 * download index, memory base, pll address and aspect ratio constants
 */
package shell_pkg;

	// ==============================
	// widths
	// ==============================
	typedef logic [26:0] ram_addr_t;
	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;
	typedef logic [9:0]  pif_addr_t;
	typedef logic [11:0] ar_dim_t;
	typedef logic [6:0]  user_port_t;
	typedef logic [1:0]  pad_idx_t;

	// ==============================
	// bundles
	// ==============================
	// download stream from the loader
	typedef struct packed {
		logic       download;
		logic [7:0] index;
		ram_addr_t  addr;
		half_t      dout;
		logic       wr;
	} dl_bus_t;

	typedef struct packed {
		logic      wren;
		pif_addr_t addr;
		word_t     data;
	} pif_wr_t;

	typedef struct packed {
		logic      wr;
		ram_addr_t addr;
		word_t     data;
	} ram_wr_t;

	typedef struct packed {
		logic      start;
		ram_addr_t size;
	} romcopy_t;

	// management bus write toward the video pll
	typedef struct packed {
		logic       write;
		logic [5:0] address;
		word_t      data;
	} pll_cfg_wr_t;

	// ==============================
	// constants
	// ==============================
	// compared against index[5:0]
	localparam logic [5:0] DL_IDX_PIF  = 6'd0;
	localparam logic [5:0] DL_IDX_CART = 6'd1;
	localparam logic [5:0] DL_IDX_GB   = 6'd2;

	// handheld image lands at 8 MB
	localparam ram_addr_t CART_GB_BASE = 27'd8388608;

	localparam logic [5:0] PLL_ADDR_MODE  = 6'd0;
	localparam logic [5:0] PLL_ADDR_MDIV  = 6'd7;
	localparam logic [5:0] PLL_ADDR_START = 6'd2;

	localparam ar_dim_t AR_DEFAULT_X = 12'd4;
	localparam ar_dim_t AR_DEFAULT_Y = 12'd3;

	// sequencer states, S7 wraps back to idle
	typedef enum logic [2:0] {
		IDLE, S1, S2, S3, S4, S5, S6, S7
	} pll_seq_t;

endpackage

/* verilog/download_router.sv */
/*
 * download router: boot rom word packing, handheld ram writes
 * with loader wait, main cart loaded flag and rom copy command
 */
`timescale 1ns/1ns

module download_router import shell_pkg::*; (
	input  logic     clk_1x,
	input  logic     rst_n,
	input  dl_bus_t  dl,
	input  logic     ram_ready,
	output logic     ioctl_wait,
	output pif_wr_t  pif,
	output ram_wr_t  ram_wr,
	output romcopy_t romcopy,
	output logic     cart_loaded
);

	logic [5:0] idx;
	logic       odd_half;
	logic       dl_fall;

	// per index activity, one cycle behind download
	logic pif_active;
	logic cart_active;
	logic gb_active;
	logic dl_q;

	logic      pif_wren;
	pif_addr_t pif_addr;
	word_t     pif_data;
	logic      ram_wr_q;
	ram_addr_t ram_addr;
	word_t     ram_data;
	logic      copy_start;
	ram_addr_t copy_size;

	assign idx      = dl.index[5:0];
	// addr bit 1 picks second half of a 32-bit word
	assign odd_half = dl.addr[1];
	// end of main cart download
	assign dl_fall  = !dl.download && dl_q && (idx == DL_IDX_CART);

	// ==============================
	// control
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			pif_active  <= 1'b0;
			cart_active <= 1'b0;
			gb_active   <= 1'b0;
			dl_q        <= 1'b0;
			pif_wren    <= 1'b0;
			ram_wr_q    <= 1'b0;
			ioctl_wait  <= 1'b0;
			copy_start  <= 1'b0;
			cart_loaded <= 1'b0;
		end else begin
			pif_active  <= dl.download && (idx == DL_IDX_PIF);
			cart_active <= dl.download && (idx == DL_IDX_CART);
			gb_active   <= dl.download && (idx == DL_IDX_GB);
			dl_q        <= dl.download;

			// single cycle strobes
			pif_wren   <= 1'b0;
			ram_wr_q   <= 1'b0;
			copy_start <= dl_fall;

			if (pif_active && dl.wr && odd_half) begin
				pif_wren <= 1'b1;
			end

			// sticky once any cart data arrived
			if (cart_active) begin
				cart_loaded <= 1'b1;
			end

			if (gb_active) begin
				if (dl.wr && odd_half) begin
					ram_wr_q   <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				// memory ack releases the loader
				if (ram_ready) begin
					ioctl_wait <= 1'b0;
				end
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// ==============================
	// payload
	// ==============================
	always_ff @(posedge clk_1x) begin
		// boot rom words are byte swapped
		if (pif_active && dl.wr) begin
			if (!odd_half) begin
				pif_data[31:24] <= dl.dout[7:0];
				pif_data[23:16] <= dl.dout[15:8];
				pif_addr        <= {dl.index[6], dl.addr[10:2]};
			end else begin
				pif_data[15:8] <= dl.dout[7:0];
				pif_data[7:0]  <= dl.dout[15:8];
			end
		end
		// handheld image, low half first
		if (gb_active && dl.wr) begin
			if (!odd_half) begin
				ram_data[15:0] <= dl.dout;
				ram_addr       <= dl.addr + CART_GB_BASE;
			end else begin
				ram_data[31:16] <= dl.dout;
			end
		end
		// last address seen is the rom size
		if (dl_fall) begin
			copy_size <= dl.addr;
		end
	end

	assign pif     = '{wren: pif_wren, addr: pif_addr, data: pif_data};
	assign ram_wr  = '{wr: ram_wr_q, addr: ram_addr, data: ram_data};
	assign romcopy = '{start: copy_start, size: copy_size};

endmodule

/* verilog/pll_reconfig_seq.sv */
/*
 * video pll reconfiguration on region change
 * two flop region sync and three-write management bus sequence
 */
`timescale 1ns/1ns

module pll_reconfig_seq import shell_pkg::*; #(
	parameter word_t CFG_WORD_PAL  = 32'd4024384270,
	parameter word_t CFG_WORD_NTSC = 32'd3274482981
) (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  logic        is_pal,
	input  logic        cfg_waitrequest,
	output pll_cfg_wr_t pll_cfg
);

	logic       pal_q1;
	logic       pal_q2;
	pll_seq_t   state;
	logic       cfg_write;
	logic [5:0] cfg_address;
	word_t      cfg_data;

	// ==============================
	// region sync and state
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			pal_q1    <= 1'b0;
			pal_q2    <= 1'b0;
			state     <= IDLE;
			cfg_write <= 1'b0;
		end else begin
			pal_q1    <= is_pal;
			pal_q2    <= pal_q1;
			cfg_write <= 1'b0;
			// a region change restarts the sequence
			if (pal_q1 != pal_q2) begin
				state <= S1;
			end else if (!cfg_waitrequest && state != IDLE) begin
				state <= pll_seq_t'(state + 3'd1);
			end
			if (!cfg_waitrequest) begin
				cfg_write <= (state == S1) || (state == S3) || (state == S5);
			end
		end
	end

	// address and data hold while the bus is busy
	always_ff @(posedge clk_1x) begin
		if (!cfg_waitrequest) begin
			case (state)
				S1: begin
					cfg_address <= PLL_ADDR_MODE;
					cfg_data    <= '0;
				end
				// divider word depends on region
				S3: begin
					cfg_address <= PLL_ADDR_MDIV;
					cfg_data    <= pal_q2 ? CFG_WORD_PAL : CFG_WORD_NTSC;
				end
				S5: begin
					cfg_address <= PLL_ADDR_START;
					cfg_data    <= '0;
				end
				default: ;
			endcase
		end
	end

	assign pll_cfg = '{write: cfg_write, address: cfg_address, data: cfg_data};

endmodule

/* verilog/aspect_ratio_sel.sv */
/*
 * aspect ratio from region and vertical crop, with user override
 */
`timescale 1ns/1ns

module aspect_ratio_sel import shell_pkg::*; (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  logic        is_pal,
	input  logic        fixed_blanks_off,
	input  logic [1:0]  crop,
	input  logic [1:0]  ar_sel,
	output logic [12:0] video_arx,
	output logic [12:0] video_ary
);

	ar_dim_t core_x;
	ar_dim_t core_y;

	// ==============================
	// core ratio table
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			core_x <= AR_DEFAULT_X;
			core_y <= AR_DEFAULT_Y;
		end else if (fixed_blanks_off) begin
			// full frame shown, plain 4:3
			core_x <= AR_DEFAULT_X;
			core_y <= AR_DEFAULT_Y;
		end else if (is_pal) begin
			case (crop)
				2'd0: begin core_x <= 12'd512;  core_y <= 12'd387;  end
				2'd1: begin core_x <= 12'd1024; core_y <= 12'd731;  end
				2'd2: begin core_x <= 12'd2048; core_y <= 12'd1419; end
				default: ;
			endcase
		end else begin
			case (crop)
				2'd0: begin core_x <= 12'd512;  core_y <= 12'd381;  end
				2'd1: begin core_x <= 12'd1280; core_y <= 12'd889;  end
				2'd2: begin core_x <= 12'd2560; core_y <= 12'd1714; end
				default: ;
			endcase
		end
	end

	// override picks full screen or custom ratio slots
	assign video_arx = (ar_sel == 2'd0) ? {1'b0, core_x} : {11'd0, ar_sel - 2'd1};
	assign video_ary = (ar_sel == 2'd0) ? {1'b0, core_y} : 13'd0;

endmodule

/* verilog/snac_port_mux.sv */
/*
 * controller serial line routing onto user port pins
 */
`timescale 1ns/1ns

module snac_port_mux import shell_pkg::*; (
	input  logic       clk_1x,
	input  logic       rst_n,
	input  logic       snac,
	input  pad_idx_t   pad_index,
	input  logic       data_out,
	input  user_port_t user_in,
	output user_port_t user_out,
	output logic       data_in
);

	logic [2:0] pin;

	// pad 0..3 on pins 1, 0, 5, 4
	function automatic logic [2:0] pad_pin(input pad_idx_t pad);
		case (pad)
			2'd0:    return 3'd1;
			2'd1:    return 3'd0;
			2'd2:    return 3'd5;
			default: return 3'd4;
		endcase
	endfunction

	assign pin = pad_pin(pad_index);

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			user_out <= '1;
			data_in  <= 1'b0;
		end else if (snac) begin
			// other pad pins keep their last level
			user_out[pin] <= data_out;
			data_in       <= user_in[pin];
			user_out[2]   <= 1'b1;
			user_out[3]   <= 1'b1;
			user_out[6]   <= 1'b1;
		end else begin
			// open drain port released
			user_out <= '1;
		end
	end

endmodule

/* verilog/core_shell_top.sv */
/*
 * shell top: download router, pll sequencer,
 * aspect ratio select and controller port mux
 */
`timescale 1ns/1ns

module core_shell_top import shell_pkg::*; #(
	parameter word_t CFG_WORD_PAL  = 32'd4024384270,
	parameter word_t CFG_WORD_NTSC = 32'd3274482981
) (
	input  logic        clk_1x,
	input  logic        rst_n,
	// download side
	input  dl_bus_t     dl,
	input  logic        ram_ready,
	output logic        ioctl_wait,
	output pif_wr_t     pif,
	output ram_wr_t     ram_wr,
	output romcopy_t    romcopy,
	output logic        cart_loaded,
	// region, shared by pll and ratio
	input  logic        is_pal,
	input  logic        cfg_waitrequest,
	output pll_cfg_wr_t pll_cfg,
	// video ratio
	input  logic        fixed_blanks_off,
	input  logic [1:0]  crop,
	input  logic [1:0]  ar_sel,
	output logic [12:0] video_arx,
	output logic [12:0] video_ary,
	// controller port
	input  logic        snac,
	input  pad_idx_t    pad_index,
	input  logic        data_out,
	input  user_port_t  user_in,
	output user_port_t  user_out,
	output logic        data_in
);

	// ==============================
	// blocks
	// ==============================
	download_router u_download_router (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.dl          (dl),
		.ram_ready   (ram_ready),
		.ioctl_wait  (ioctl_wait),
		.pif         (pif),
		.ram_wr      (ram_wr),
		.romcopy     (romcopy),
		.cart_loaded (cart_loaded)
	);

	pll_reconfig_seq #(
		.CFG_WORD_PAL  (CFG_WORD_PAL),
		.CFG_WORD_NTSC (CFG_WORD_NTSC)
	) u_pll_reconfig_seq (
		.clk_1x          (clk_1x),
		.rst_n           (rst_n),
		.is_pal          (is_pal),
		.cfg_waitrequest (cfg_waitrequest),
		.pll_cfg         (pll_cfg)
	);

	aspect_ratio_sel u_aspect_ratio_sel (
		.clk_1x           (clk_1x),
		.rst_n            (rst_n),
		.is_pal           (is_pal),
		.fixed_blanks_off (fixed_blanks_off),
		.crop             (crop),
		.ar_sel           (ar_sel),
		.video_arx        (video_arx),
		.video_ary        (video_ary)
	);

	snac_port_mux u_snac_port_mux (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.snac      (snac),
		.pad_index (pad_index),
		.data_out  (data_out),
		.user_in   (user_in),
		.user_out  (user_out),
		.data_in   (data_in)
	);

endmodule

/* verif/core_shell_sva.sv */
/*
 * bound assertions for the shell top
 * strobe widths, reset values, wait level and port release
 */
`timescale 1ns/1ns

module core_shell_sva import shell_pkg::*; (
	input logic        clk_1x,
	input logic        rst_n,
	input dl_bus_t     dl,
	input logic        ioctl_wait,
	input pif_wr_t     pif,
	input ram_wr_t     ram_wr,
	input romcopy_t    romcopy,
	input logic        cart_loaded,
	input logic        cfg_waitrequest,
	input pll_cfg_wr_t pll_cfg,
	input logic        snac,
	input user_port_t  user_out
);

	// ==============================
	// reset state
	// ==============================
	a_reset_values: assert property (@(posedge clk_1x)
		!rst_n |=> (!pif.wren && !ram_wr.wr && !ioctl_wait && !romcopy.start
			&& !cart_loaded && !pll_cfg.write && user_out == 7'h7f))
		else $error("outputs not cleared by reset");

	// ==============================
	// strobes
	// ==============================
	a_pif_pulse: assert property (@(posedge clk_1x) disable iff (!rst_n)
		pif.wren |=> !pif.wren)
		else $error("boot rom write longer than one cycle");

	a_ram_pulse: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr.wr |=> !ram_wr.wr)
		else $error("ram write longer than one cycle");

	// loader held from the write itself
	a_wait_with_write: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr.wr |-> ioctl_wait)
		else $error("ram write without wait level");

	a_copy_pulse: assert property (@(posedge clk_1x) disable iff (!rst_n)
		romcopy.start |=> !romcopy.start)
		else $error("rom copy start longer than one cycle");

	// start only after a main cart download ends
	a_copy_cause: assert property (@(posedge clk_1x) disable iff (!rst_n)
		romcopy.start |-> ($past(dl.index[5:0]) == DL_IDX_CART)
			&& !$past(dl.download) && $past(dl.download, 2))
		else $error("rom copy start without end of cart download");

	a_pll_pulse: assert property (@(posedge clk_1x) disable iff (!rst_n)
		pll_cfg.write |=> !pll_cfg.write)
		else $error("pll write longer than one cycle");

	a_pll_busy: assert property (@(posedge clk_1x) disable iff (!rst_n)
		cfg_waitrequest |=> !pll_cfg.write)
		else $error("pll write issued while bus busy");

	// ==============================
	// user port
	// ==============================
	a_port_released: assert property (@(posedge clk_1x) disable iff (!rst_n)
		!snac |=> user_out == 7'h7f)
		else $error("user port not released with snac off");

	a_fixed_pins: assert property (@(posedge clk_1x) disable iff (!rst_n)
		snac |=> (user_out[2] && user_out[3] && user_out[6]))
		else $error("pins 2, 3 or 6 not high with snac on");

endmodule

bind core_shell_top core_shell_sva u_sva (
	.clk_1x          (clk_1x),
	.rst_n           (rst_n),
	.dl              (dl),
	.ioctl_wait      (ioctl_wait),
	.pif             (pif),
	.ram_wr          (ram_wr),
	.romcopy         (romcopy),
	.cart_loaded     (cart_loaded),
	.cfg_waitrequest (cfg_waitrequest),
	.pll_cfg         (pll_cfg),
	.snac            (snac),
	.user_out        (user_out)
);

/* verif/tb_core_shell.sv */
/*
 * testbench for the shell top with download, pll, ratio and port tests
 * xorshift stimulus, cycle limit and pass/fail reporting
 */
`timescale 1ns/1ns

module tb_core_shell import shell_pkg::*;;

	localparam word_t PAL_WORD  = 32'd4024384270;
	localparam word_t NTSC_WORD = 32'd3274482981;
	localparam int    MAX_CYCLES = 3000;

	logic        clk_1x = 1'b0;
	logic        rst_n;
	dl_bus_t     dl;
	logic        ram_ready;
	logic        ioctl_wait;
	pif_wr_t     pif;
	ram_wr_t     ram_wr;
	romcopy_t    romcopy;
	logic        cart_loaded;
	logic        is_pal;
	logic        cfg_waitrequest;
	pll_cfg_wr_t pll_cfg;
	logic        fixed_blanks_off;
	logic [1:0]  crop;
	logic [1:0]  ar_sel;
	logic [12:0] video_arx;
	logic [12:0] video_ary;
	logic        snac;
	pad_idx_t    pad_index;
	logic        data_out;
	user_port_t  user_in;
	user_port_t  user_out;
	logic        data_in;

	logic [31:0] rng_state = 32'd26;
	int          cycles = 0;

	core_shell_top #(
		.CFG_WORD_PAL  (PAL_WORD),
		.CFG_WORD_NTSC (NTSC_WORD)
	) UUT (.*);

	always #4 clk_1x = ~clk_1x;

	// ==============================
	// helpers
	// ==============================
	always @(posedge clk_1x) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "cycle limit reached");
		end
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic fail_now(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "first error");
	endtask

	task automatic expect_eq(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp)
			else fail_now($sformatf("%s got %0h expected %0h", what, got, exp));
	endtask

	// next inputs go in once outputs have settled
	task automatic step();
		@(posedge clk_1x);
		#1;
	endtask

	// ==============================
	// download tests
	// ==============================
	task automatic run_pif_test();
		logic [31:0] r;
		logic        bit6;
		ram_addr_t   a;
		r = next_rand();
		bit6 = r[0];
		dl.index = {1'b0, bit6, 6'd0};
		dl.download = 1'b1;
		step();
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			a = ram_addr_t'({r[26:18], 2'b00});
			dl.addr = a;
			dl.dout = r[15:0];
			dl.wr = 1'b1;
			step();
			dl.addr = a + 27'd2;
			dl.dout = r[31:16];
			step();
			dl.wr = 1'b0;
			expect_eq("pif wren", 64'(pif.wren), 64'd1);
			expect_eq("pif addr", 64'(pif.addr), 64'({bit6, a[10:2]}));
			expect_eq("pif data", 64'(pif.data),
				64'({r[7:0], r[15:8], r[23:16], r[31:24]}));
			step();
			expect_eq("pif wren after pulse", 64'(pif.wren), 64'd0);
		end
		dl.download = 1'b0;
		step();
	endtask

	task automatic run_gb_test();
		logic [31:0] r;
		logic [31:0] d;
		ram_addr_t   a;
		dl.index = 8'd2;
		dl.download = 1'b1;
		step();
		for (int i = 0; i < 10; i++) begin
			r = next_rand();
			d = next_rand();
			a = ram_addr_t'({d[20:2], 2'b00});
			dl.addr = a;
			dl.dout = r[15:0];
			dl.wr = 1'b1;
			step();
			dl.addr = a + 27'd2;
			dl.dout = r[31:16];
			step();
			dl.wr = 1'b0;
			expect_eq("ram wr", 64'(ram_wr.wr), 64'd1);
			expect_eq("ram addr", 64'(ram_wr.addr), 64'(a + 27'd8388608));
			expect_eq("ram data", 64'(ram_wr.data), 64'(r));
			expect_eq("wait on write", 64'(ioctl_wait), 64'd1);
			// memory answers after 1 to 5 cycles
			d = (next_rand() % 5) + 1;
			for (int k = 1; k < d; k++) begin
				step();
				expect_eq("wait held", 64'(ioctl_wait), 64'd1);
			end
			ram_ready = 1'b1;
			step();
			ram_ready = 1'b0;
			expect_eq("wait after ready", 64'(ioctl_wait), 64'd0);
		end
		dl.download = 1'b0;
		step();
	endtask

	task automatic run_cart_test();
		ram_addr_t a;
		a = ram_addr_t'(next_rand() % 1024) << 1;
		expect_eq("cart not loaded yet", 64'(cart_loaded), 64'd0);
		dl.index = 8'd1;
		dl.download = 1'b1;
		for (int i = 0; i < 6; i++) begin
			dl.addr = a;
			dl.dout = half_t'(next_rand());
			dl.wr = 1'b1;
			step();
			dl.wr = 1'b0;
			step();
			a = a + 27'd2;
		end
		expect_eq("cart loaded", 64'(cart_loaded), 64'd1);
		expect_eq("no early copy", 64'(romcopy.start), 64'd0);
		dl.download = 1'b0;
		step();
		expect_eq("copy start", 64'(romcopy.start), 64'd1);
		expect_eq("copy size", 64'(romcopy.size), 64'(dl.addr));
		step();
		expect_eq("copy start once", 64'(romcopy.start), 64'd0);
		expect_eq("cart still loaded", 64'(cart_loaded), 64'd1);
	endtask

	// ==============================
	// pll, ratio and port tests
	// ==============================
	task automatic collect_pll_writes(input word_t div_word);
		int n;
		n = 0;
		for (int c = 0; c < 30 && n < 3; c++) begin
			step();
			if (pll_cfg.write) begin
				case (n)
					0: begin
						expect_eq("mode addr", 64'(pll_cfg.address), 64'd0);
						expect_eq("mode data", 64'(pll_cfg.data), 64'd0);
					end
					1: begin
						expect_eq("mdiv addr", 64'(pll_cfg.address), 64'd7);
						expect_eq("mdiv data", 64'(pll_cfg.data), 64'(div_word));
					end
					default: begin
						expect_eq("start addr", 64'(pll_cfg.address), 64'd2);
						expect_eq("start data", 64'(pll_cfg.data), 64'd0);
					end
				endcase
				n++;
			end
		end
		if (n != 3) begin
			fail_now($sformatf("pll sequence gave %0d writes, expected 3", n));
		end
		for (int c = 0; c < 10; c++) begin
			step();
			expect_eq("extra pll write", 64'(pll_cfg.write), 64'd0);
		end
	endtask

	task automatic run_pll_test();
		cfg_waitrequest = 1'b0;
		is_pal = 1'b1;
		collect_pll_writes(PAL_WORD);
		// busy bus holds the sequence
		cfg_waitrequest = 1'b1;
		is_pal = 1'b0;
		for (int c = 0; c < 12; c++) begin
			step();
			expect_eq("write while busy", 64'(pll_cfg.write), 64'd0);
		end
		cfg_waitrequest = 1'b0;
		collect_pll_writes(NTSC_WORD);
	endtask

	task automatic run_aspect_test();
		logic [31:0] r;
		logic [11:0] ex;
		logic [11:0] ey;
		fixed_blanks_off = 1'b1;
		ar_sel = 2'd0;
		step();
		ex = 12'd4;
		ey = 12'd3;
		for (int i = 0; i < 60; i++) begin
			r = next_rand();
			// region held long enough for a full pll sequence
			if (i % 10 == 0) begin
				is_pal = r[0];
			end
			fixed_blanks_off = r[1] & r[2];
			crop = r[4:3];
			ar_sel = r[7] ? 2'd0 : r[6:5];
			step();
			// ratio table per region and crop
			if (fixed_blanks_off) begin
				ex = 12'd4;
				ey = 12'd3;
			end else if (crop == 2'd0) begin
				ex = 12'd512;
				ey = is_pal ? 12'd387 : 12'd381;
			end else if (crop == 2'd1) begin
				ex = is_pal ? 12'd1024 : 12'd1280;
				ey = is_pal ? 12'd731 : 12'd889;
			end else if (crop == 2'd2) begin
				ex = is_pal ? 12'd2048 : 12'd2560;
				ey = is_pal ? 12'd1419 : 12'd1714;
			end
			if (ar_sel == 2'd0) begin
				expect_eq("arx core", 64'(video_arx), 64'(ex));
				expect_eq("ary core", 64'(video_ary), 64'(ey));
			end else begin
				expect_eq("arx override", 64'(video_arx), 64'(ar_sel) - 64'd1);
				expect_eq("ary override", 64'(video_ary), 64'd0);
			end
		end
	endtask

	task automatic run_snac_test();
		logic [31:0] r;
		int          pin;
		snac = 1'b1;
		for (int i = 0; i < 24; i++) begin
			r = next_rand();
			pad_index = r[1:0];
			data_out = r[2];
			user_in = r[9:3];
			step();
			case (pad_index)
				2'd0: pin = 1;
				2'd1: pin = 0;
				2'd2: pin = 5;
				default: pin = 4;
			endcase
			expect_eq("pad pin out", 64'(user_out[pin]), 64'(data_out));
			expect_eq("pad pin in", 64'(data_in), 64'(user_in[pin]));
			expect_eq("fixed pins", 64'({user_out[6], user_out[3], user_out[2]}), 64'd7);
		end
		snac = 1'b0;
		step();
		expect_eq("port released", 64'(user_out), 64'h7f);
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		rst_n = 1'b0;
		dl = '0;
		ram_ready = 1'b0;
		is_pal = 1'b0;
		cfg_waitrequest = 1'b0;
		fixed_blanks_off = 1'b0;
		crop = 2'd0;
		ar_sel = 2'd0;
		snac = 1'b0;
		pad_index = 2'd0;
		data_out = 1'b0;
		user_in = '0;
		step();
		step();
		expect_eq("reset arx", 64'(video_arx), 64'd4);
		expect_eq("reset ary", 64'(video_ary), 64'd3);
		rst_n = 1'b1;
		step();
		run_pif_test();
		run_gb_test();
		run_cart_test();
		run_pll_test();
		run_aspect_test();
		run_snac_test();
		step();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* src.f */
verilog/shell_pkg.sv
verilog/download_router.sv
verilog/pll_reconfig_seq.sv
verilog/aspect_ratio_sel.sv
verilog/snac_port_mux.sv
verilog/core_shell_top.sv
verif/core_shell_sva.sv
verif/tb_core_shell.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_core_shell -f src.f
status=0
./obj_dir/Vtb_core_shell > sim.log 2>&1 || status=$?
cat sim.log
if grep -qF "*** TEST FAILED ***" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
